//--- vlog.f
+incdir+include
verilog/core_pkg.sv
verilog/mul_iter.sv
verilog/instr_decode.sv
verilog/instr_queue.sv
verilog/exec_retire.sv
verilog/core_top.sv
testbench/tb_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator and run it.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_core -f vlog.f \
    && ./obj_dir/Vtb_core \
    || exit 1

//--- testbench/tb_core.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Core testbench
// Random instruction packets into the fetch port,
// retirements checked against a reference model
//////////////////////////////////////////////////
`include "core_params.svh"

module tb_core;
    import core_pkg::*;

    // Packet counts per test phase
    localparam int N_INIT     = 16;
    localparam int N_DIRECTED = 3;
    localparam int N_RANDOM   = 60;
    localparam int N_DEPEND   = 30;
    localparam int N_MIX      = 20;
    localparam int N_BURST    = 12;
    localparam int N_ILLEGAL  = 20;
    localparam int N_PKTS     = N_INIT + N_DIRECTED + N_RANDOM + N_DEPEND + N_MIX +
                                N_BURST + N_ILLEGAL;
    localparam int WATCHDOG_CYCLES = 40 * (2 * N_PKTS) + 200;

    logic              clk_i;
    logic              rst_n_i;
    logic              fetch_valid_i;
    fetch_pkt_s        fetch_i;
    logic              fetch_ready_o;
    retire_s [1:0]     retire_o;

    logic [31:0]       model_regs [`CORE_NUM_REGS];
    retire_s           exp_q [$];
    logic [31:0]       next_pc;
    logic              stall_seen;

    core_top DUT (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_valid_i(fetch_valid_i),
        .fetch_i      (fetch_i),
        .fetch_ready_o(fetch_ready_o),
        .retire_o     (retire_o)
    );

    always #2 clk_i = ~clk_i;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else stop_with_failure($sformatf(
            "error at time %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    //////////////////////////////////////////////////
    // Instruction encoders
    //////////////////////////////////////////////////
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($urandom_range(0, 31));
    endfunction

    function automatic logic [31:0] rand_alu_r(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        int unsigned k;
        k = $urandom_range(0, 9);
        if (k == 8) begin
            return enc_r(7'h20, rs2, rs1, 3'd0, rd);
        end else if (k == 9) begin
            return enc_r(7'h20, rs2, rs1, 3'd5, rd);
        end
        return enc_r(7'h00, rs2, rs1, 3'(k), rd);
    endfunction

    function automatic logic [31:0] rand_alu_i(input logic [4:0] rd, input logic [4:0] rs1);
        logic [2:0]  f3;
        logic [11:0] imm;
        f3  = 3'($urandom_range(0, 7));
        imm = 12'($urandom);
        // Shift encodings keep a legal upper field
        if (f3 == 3'd1) begin
            imm[11:5] = 7'h00;
        end else if (f3 == 3'd5) begin
            imm[11:5] = ($urandom_range(0, 1) != 0) ? 7'h20 : 7'h00;
        end
        return enc_i(imm, rs1, f3, rd);
    endfunction

    function automatic logic [31:0] rand_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        if ($urandom_range(0, 1) != 0) begin
            return rand_alu_r(rd, rs1, rs2);
        end
        return rand_alu_i(rd, rs1);
    endfunction

    function automatic logic [31:0] illegal_instr();
        logic [31:0] w;
        w = $urandom;
        case ($urandom_range(0, 5))
            0:       w[6:0] = 7'h03;
            1:       w[6:0] = 7'h23;
            2:       w[6:0] = 7'h63;
            3:       w[6:0] = 7'h6f;
            4:       w[6:0] = 7'h37;
            default: begin
                // M-extension ops other than MUL
                w[6:0]   = 7'h33;
                w[31:25] = 7'h01;
                w[14:12] = 3'($urandom_range(1, 7));
            end
        endcase
        return w;
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic logic [31:0] base_alu(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'd0:    res = a + b;
            3'd1:    res = a << b[4:0];
            3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    res = (a < b) ? 32'd1 : 32'd0;
            3'd4:    res = a ^ b;
            3'd5:    res = a >> b[4:0];
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic retire_s ref_model(input logic [31:0] pc, input logic [31:0] instr);
        retire_s     r;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        ok;
        f7  = instr[31:25];
        f3  = instr[14:12];
        rd  = instr[11:7];
        a   = model_regs[instr[19:15]];
        b   = model_regs[instr[24:20]];
        ok  = 1'b1;
        res = '0;
        if (instr[6:0] == 7'h33) begin
            if (f7 == 7'h01 && f3 == 3'd0) begin
                res = a * b;
            end else if (f7 == 7'h20 && f3 == 3'd0) begin
                res = a - b;
            end else if (f7 == 7'h20 && f3 == 3'd5) begin
                res = $signed(a) >>> b[4:0];
            end else if (f7 == 7'h00) begin
                res = base_alu(f3, a, b);
            end else begin
                ok = 1'b0;
            end
        end else if (instr[6:0] == 7'h13) begin
            if (f3 == 3'd1) begin
                ok  = f7 == 7'h00;
                res = a << instr[24:20];
            end else if (f3 == 3'd5 && f7 == 7'h00) begin
                res = a >> instr[24:20];
            end else if (f3 == 3'd5 && f7 == 7'h20) begin
                res = $signed(a) >>> instr[24:20];
            end else if (f3 == 3'd5) begin
                ok = 1'b0;
            end else begin
                res = base_alu(f3, a, {{20{instr[31]}}, instr[31:20]});
            end
        end else begin
            ok = 1'b0;
        end
        if (ok && rd != 5'd0) begin
            model_regs[rd] = res;
        end
        r.valid   = 1'b1;
        r.pc      = pc;
        r.rd      = rd;
        r.wdata   = ok ? res : 32'd0;
        r.illegal = !ok;
        return r;
    endfunction

    // Drive one packet, hold it until accepted, then log its expected retirements
    task automatic send_packet(input logic [31:0] instr0, input logic two,
                               input logic [31:0] instr1);
        fetch_pkt_s pkt;
        logic       taken;
        pkt.slot[0] = '{valid: 1'b1, pc: next_pc, instr: instr0};
        pkt.slot[1] = '{valid: two, pc: next_pc + 32'd4, instr: instr1};
        fetch_valid_i <= 1'b1;
        fetch_i       <= pkt;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk_i);
            taken = fetch_ready_o;
            if (!taken) begin
                stall_seen = 1'b1;
            end
            @(posedge clk_i);
        end
        exp_q.push_back(ref_model(pkt.slot[0].pc, instr0));
        if (two) begin
            exp_q.push_back(ref_model(pkt.slot[1].pc, instr1));
        end
        next_pc = next_pc + (two ? 32'd8 : 32'd4);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin : stimulus
        logic [4:0] rd0;
        void'($urandom(21654));
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_i       = '0;
        next_pc       = 32'h0000_1000;
        stall_seen    = 1'b0;
        for (int r = 0; r < `CORE_NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);

        // Seed every register through ADDI
        for (int r = 1; r < 32; r += 2) begin
            send_packet(enc_i(12'($urandom), 5'd0, 3'd0, 5'(r)), r < 31,
                        enc_i(12'($urandom), 5'd0, 3'd0, 5'(r + 1)));
        end

        // SUB, SRA, SLTU, SRAI and SLTIU at least once
        send_packet(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3), 1'b1,
                    enc_r(7'h20, 5'd4, 5'd5, 3'd5, 5'd6));
        send_packet(enc_r(7'h00, 5'd7, 5'd8, 3'd3, 5'd9), 1'b1,
                    enc_i({7'h20, 5'd7}, 5'd10, 3'd5, 5'd11));
        send_packet(enc_i(12'hfff, 5'd12, 3'd3, 5'd13), 1'b0, 32'd0);

        for (int p = 0; p < N_RANDOM; p++) begin
            send_packet(rand_alu(rand_reg(), rand_reg(), rand_reg()), 1'b1,
                        rand_alu(rand_reg(), rand_reg(), rand_reg()));
        end

        // Slot 1 reads the rd of slot 0, sometimes x0
        for (int p = 0; p < N_DEPEND; p++) begin
            rd0 = ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
            send_packet(rand_alu(rd0, rand_reg(), rand_reg()), 1'b1,
                        rand_alu(rand_reg(), rd0,
                                 ($urandom_range(0, 1) != 0) ? rd0 : rand_reg()));
        end

        for (int p = 0; p < N_MIX; p++) begin
            send_packet(($urandom_range(0, 1) != 0) ?
                        enc_r(7'h01, rand_reg(), rand_reg(), 3'd0, rand_reg()) :
                        rand_alu(rand_reg(), rand_reg(), rand_reg()), 1'b1,
                        ($urandom_range(0, 1) != 0) ?
                        enc_r(7'h01, rand_reg(), rand_reg(), 3'd0, rand_reg()) :
                        rand_alu(rand_reg(), rand_reg(), rand_reg()));
        end

        // Back-to-back MUL pairs fill the queue
        stall_seen = 1'b0;
        for (int p = 0; p < N_BURST; p++) begin
            send_packet(enc_r(7'h01, rand_reg(), rand_reg(), 3'd0, rand_reg()), 1'b1,
                        enc_r(7'h01, rand_reg(), rand_reg(), 3'd0, rand_reg()));
        end
        assert (stall_seen) else
            stop_with_failure("fetch_ready_o never dropped during the MUL burst");

        for (int p = 0; p < N_ILLEGAL; p++) begin
            send_packet(($urandom_range(0, 1) != 0) ? illegal_instr() :
                        rand_alu(rand_reg(), rand_reg(), rand_reg()),
                        $urandom_range(0, 1) != 0,
                        ($urandom_range(0, 1) != 0) ? illegal_instr() :
                        rand_alu(rand_reg(), rand_reg(), rand_reg()));
        end
        fetch_valid_i <= 1'b0;

        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        // Quiet period to catch duplicated retirements
        repeat (10) @(negedge clk_i);
        $display("TB PASSED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Retirement compare
    //////////////////////////////////////////////////
    always @(negedge clk_i) begin : compare_retire
        retire_s exp_ret;
        if (rst_n_i) begin
            assert (retire_o[0].valid || !retire_o[1].valid) else
                stop_with_failure("retire slot 1 was valid while slot 0 was not");
            for (int s = 0; s < 2; s++) begin
                if (retire_o[s].valid) begin
                    assert (exp_q.size() != 0) else
                        stop_with_failure("an instruction retired that was never accepted");
                    exp_ret = exp_q.pop_front();
                    check_field($sformatf("retire_o[%0d].pc", s), retire_o[s].pc, exp_ret.pc);
                    check_field($sformatf("retire_o[%0d].rd", s), 32'(retire_o[s].rd),
                                32'(exp_ret.rd));
                    check_field($sformatf("retire_o[%0d].wdata", s), retire_o[s].wdata,
                                exp_ret.wdata);
                    check_field($sformatf("retire_o[%0d].illegal", s),
                                32'(retire_o[s].illegal), 32'(exp_ret.illegal));
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        stop_with_failure($sformatf("retirement stalled with %0d instructions outstanding",
                                    exp_q.size()));
    end

endmodule

//--- verilog/core_top.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Core top level
// Decode, instruction queue and execute/retire
//////////////////////////////////////////////////

module core_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    fetch_valid_i,
    input  core_pkg::fetch_pkt_s    fetch_i,
    output logic                    fetch_ready_o,
    output core_pkg::retire_s [1:0] retire_o
);
    import core_pkg::*;

    logic           fetch_fire;
    dec_op_s [1:0]  push_ops;
    logic [1:0]     push_cnt;
    dec_op_s [1:0]  head_ops;
    logic [1:0]     avail;
    logic [1:0]     pop_cnt;

    // Fetch handshake completes on valid and ready
    assign fetch_fire = fetch_valid_i & fetch_ready_o;

    instr_decode u_decode (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_valid_i(fetch_fire),
        .fetch_i      (fetch_i),
        .push_o       (push_ops),
        .push_cnt_o   (push_cnt)
    );

    instr_queue u_queue (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .push_i    (push_ops),
        .push_cnt_i(push_cnt),
        .head_o    (head_ops),
        .avail_o   (avail),
        .pop_cnt_i (pop_cnt),
        .ready_o   (fetch_ready_o)
    );

    exec_retire u_exec (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .head_i   (head_ops),
        .avail_i  (avail),
        .pop_cnt_o(pop_cnt),
        .retire_o (retire_o)
    );

endmodule

//--- verilog/exec_retire.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Execute and retire
// Register file, in-order dual ALU issue with
// bypass, MUL stall and registered retirement
//////////////////////////////////////////////////
`include "core_params.svh"

module exec_retire (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  core_pkg::dec_op_s [1:0] head_i,
    input  logic [1:0]              avail_i,
    output logic [1:0]              pop_cnt_o,
    output core_pkg::retire_s [1:0] retire_o
);
    import core_pkg::*;

    localparam int XLEN = `CORE_XLEN;

    logic [XLEN-1:0]         regs [`CORE_NUM_REGS];
    logic [XLEN-1:0]         op_a [2];
    logic [XLEN-1:0]         op_b [2];
    logic [XLEN-1:0]         alu_res [2];
    retire_s                 slot_ret [2];
    logic [1:0]              slot_wr;
    logic [1:0]              slot_retire;
    logic                    mul_start;
    logic                    mul_pend;
    logic                    mul_done;
    logic [XLEN-1:0]         mul_product;
    logic [XLEN-1:0]         mul_pc;
    logic [`CORE_REG_AW-1:0] mul_rd;

    function automatic logic [XLEN-1:0] alu(input alu_op_e op,
                                            input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: return {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return '0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Issue selection
    //////////////////////////////////////////////////
    always_comb begin
        pop_cnt_o = 2'd0;
        mul_start = 1'b0;
        if (!mul_pend && avail_i != 2'd0) begin
            if (head_i[0].op == ALU_MUL) begin
                pop_cnt_o = 2'd1;
                mul_start = 1'b1;
            end else if (avail_i == 2'd1 || head_i[1].op == ALU_MUL) begin
                // A MUL in slot 1 waits to become the head
                pop_cnt_o = 2'd1;
            end else begin
                pop_cnt_o = 2'd2;
            end
        end
        slot_retire[0] = (pop_cnt_o != 2'd0) && !mul_start;
        slot_retire[1] = pop_cnt_o == 2'd2;
    end

    // Operands and results, slot 1 sees slot 0 through the bypass
    always_comb begin
        op_a[0]    = regs[head_i[0].rs1];
        op_b[0]    = head_i[0].use_imm ? head_i[0].imm : regs[head_i[0].rs2];
        alu_res[0] = alu(head_i[0].op, op_a[0], op_b[0]);
        slot_wr[0] = head_i[0].op != ALU_ILLEGAL && head_i[0].rd != '0;

        op_a[1] = (slot_wr[0] && head_i[1].rs1 == head_i[0].rd) ?
                  alu_res[0] : regs[head_i[1].rs1];
        if (head_i[1].use_imm) begin
            op_b[1] = head_i[1].imm;
        end else if (slot_wr[0] && head_i[1].rs2 == head_i[0].rd) begin
            op_b[1] = alu_res[0];
        end else begin
            op_b[1] = regs[head_i[1].rs2];
        end
        alu_res[1] = alu(head_i[1].op, op_a[1], op_b[1]);
        slot_wr[1] = head_i[1].op != ALU_ILLEGAL && head_i[1].rd != '0;

        for (int s = 0; s < 2; s++) begin
            slot_ret[s].valid   = 1'b1;
            slot_ret[s].pc      = head_i[s].pc;
            slot_ret[s].rd      = head_i[s].rd;
            slot_ret[s].illegal = head_i[s].op == ALU_ILLEGAL;
            slot_ret[s].wdata   = slot_ret[s].illegal ? '0 : alu_res[s];
        end
    end

    mul_iter u_mul (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (mul_start),
        .a_i      (op_a[0]),
        .b_i      (op_b[0]),
        .done_o   (mul_done),
        .product_o(mul_product)
    );

    // Pending MUL destination
    always_ff @(posedge clk_i) begin
        if (mul_start) begin
            mul_pc <= head_i[0].pc;
            mul_rd <= head_i[0].rd;
        end
    end

    //////////////////////////////////////////////////
    // Writeback and retirement
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mul_pend <= 1'b0;
            retire_o <= '0;
            for (int r = 0; r < `CORE_NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            retire_o <= '0;
            if (mul_start) begin
                mul_pend <= 1'b1;
            end else if (mul_done) begin
                mul_pend <= 1'b0;
            end
            if (mul_done) begin
                retire_o[0] <= '{valid: 1'b1, pc: mul_pc, rd: mul_rd,
                                 wdata: mul_product, illegal: 1'b0};
                if (mul_rd != '0) begin
                    regs[mul_rd] <= mul_product;
                end
            end else begin
                // Slot 1 is younger, so its write lands last
                for (int s = 0; s < 2; s++) begin
                    if (slot_retire[s]) begin
                        retire_o[s] <= slot_ret[s];
                        if (slot_wr[s]) begin
                            regs[slot_ret[s].rd] <= slot_ret[s].wdata;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- verilog/instr_queue.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Instruction queue
// Circular buffer with two pushes and two pops
// per cycle between decode and execution
//////////////////////////////////////////////////
`include "core_params.svh"

module instr_queue (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  core_pkg::dec_op_s [1:0] push_i,
    input  logic [1:0]              push_cnt_i,
    output core_pkg::dec_op_s [1:0] head_o,
    output logic [1:0]              avail_o,
    input  logic [1:0]              pop_cnt_i,
    output logic                    ready_o
);
    import core_pkg::*;

    localparam int DEPTH = `CORE_QUEUE_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    dec_op_s      mem [DEPTH];
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_nxt;
    logic [AW-1:0] wr_nxt;
    logic [AW:0]   count;
    logic [AW:0]   free;

    assign rd_nxt = rd_ptr + 1'b1;
    assign wr_nxt = wr_ptr + 1'b1;
    assign free   = (AW+1)'(DEPTH) - count;

    assign head_o[0] = mem[rd_ptr];
    assign head_o[1] = mem[rd_nxt];
    assign avail_o   = (count >= (AW+1)'(2)) ? 2'd2 : count[1:0];

    // Room for the pair held in decode plus one more pair
    assign ready_o = free >= (AW+1)'(4);

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + AW'(pop_cnt_i);
            wr_ptr <= wr_ptr + AW'(push_cnt_i);
            count  <= count + (AW+1)'(push_cnt_i) - (AW+1)'(pop_cnt_i);
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push_cnt_i != 2'd0) begin
            mem[wr_ptr] <= push_i[0];
        end
        if (push_cnt_i == 2'd2) begin
            mem[wr_nxt] <= push_i[1];
        end
    end

    //////////////////////////////////////////////////
    // Protocol checks on both sides
    //////////////////////////////////////////////////
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (AW+1)'(pop_cnt_i) <= count);

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (AW+1)'(push_cnt_i) <= free);

endmodule

//--- verilog/instr_decode.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Instruction decode
// Turns an accepted fetch pair into micro-ops and
// strobes them into the instruction queue
//////////////////////////////////////////////////
`include "core_params.svh"

module instr_decode (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   fetch_valid_i,
    input  core_pkg::fetch_pkt_s   fetch_i,
    output core_pkg::dec_op_s [1:0] push_o,
    output logic [1:0]             push_cnt_o
);
    import core_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] F7_BASE    = 7'h00;
    localparam logic [6:0] F7_ALT     = 7'h20;
    localparam logic [6:0] F7_MULDIV  = 7'h01;

    function automatic dec_op_s decode_slot(input fetch_slot_s slot);
        instr_word_u w;
        dec_op_s     d;
        w         = slot.instr;
        d.pc      = slot.pc;
        d.rd      = w.r.rd;
        d.rs1     = w.r.rs1;
        d.rs2     = w.r.rs2;
        d.use_imm = 1'b0;
        d.imm     = {{(`CORE_XLEN-12){w.i.imm[11]}}, w.i.imm};
        d.op      = ALU_ILLEGAL;
        case (w.r.opcode)
            OPC_OP: begin
                case ({w.r.funct7, w.r.funct3})
                    {F7_BASE, 3'b000}:   d.op = ALU_ADD;
                    {F7_ALT, 3'b000}:    d.op = ALU_SUB;
                    {F7_BASE, 3'b001}:   d.op = ALU_SLL;
                    {F7_BASE, 3'b010}:   d.op = ALU_SLT;
                    {F7_BASE, 3'b011}:   d.op = ALU_SLTU;
                    {F7_BASE, 3'b100}:   d.op = ALU_XOR;
                    {F7_BASE, 3'b101}:   d.op = ALU_SRL;
                    {F7_ALT, 3'b101}:    d.op = ALU_SRA;
                    {F7_BASE, 3'b110}:   d.op = ALU_OR;
                    {F7_BASE, 3'b111}:   d.op = ALU_AND;
                    {F7_MULDIV, 3'b000}: d.op = ALU_MUL;
                    default:             d.op = ALU_ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                d.use_imm = 1'b1;
                case (w.i.funct3)
                    3'b000: d.op = ALU_ADD;
                    3'b010: d.op = ALU_SLT;
                    3'b011: d.op = ALU_SLTU;
                    3'b100: d.op = ALU_XOR;
                    3'b110: d.op = ALU_OR;
                    3'b111: d.op = ALU_AND;
                    default: begin
                        // Shifts take the amount from imm[4:0], funct7[5] picks SRA
                        d.imm = {{(`CORE_XLEN-5){1'b0}}, w.i.imm[4:0]};
                        if (w.r.funct7 == F7_BASE) begin
                            d.op = (w.i.funct3 == 3'b001) ? ALU_SLL : ALU_SRL;
                        end else if (w.r.funct7 == F7_ALT && w.i.funct3 == 3'b101) begin
                            d.op = ALU_SRA;
                        end
                    end
                endcase
            end
            default: d.op = ALU_ILLEGAL;
        endcase
        return d;
    endfunction

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            push_cnt_o <= 2'd0;
        end else if (fetch_valid_i) begin
            push_cnt_o <= 2'(fetch_i.slot[0].valid) + 2'(fetch_i.slot[1].valid);
        end else begin
            push_cnt_o <= 2'd0;
        end
    end

    // Micro-op pair, qualified by push_cnt_o
    always_ff @(posedge clk_i) begin
        if (fetch_valid_i) begin
            push_o[0] <= decode_slot(fetch_i.slot[0]);
            push_o[1] <= decode_slot(fetch_i.slot[1]);
        end
    end

    // Fetch never hands over a lone younger slot
    a_slot_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_valid_i |-> (fetch_i.slot[0].valid || !fetch_i.slot[1].valid));

endmodule

//--- verilog/mul_iter.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Iterative multiplier
// One multiplier digit per cycle, low word out
//////////////////////////////////////////////////
`include "core_params.svh"

module mul_iter (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  start_i,
    input  logic [`CORE_XLEN-1:0] a_i,
    input  logic [`CORE_XLEN-1:0] b_i,
    output logic                  done_o,
    output logic [`CORE_XLEN-1:0] product_o
);
    localparam int XLEN   = `CORE_XLEN;
    localparam int STEP   = `CORE_MUL_STEP;
    localparam int NSTEPS = XLEN / STEP;
    localparam int CW     = $clog2(NSTEPS);

    logic            busy;
    logic [CW-1:0]   step_cnt;
    logic [XLEN-1:0] mcand;
    logic [XLEN-1:0] mplier;
    logic [XLEN-1:0] acc;
    logic [XLEN-1:0] partial;

    // Shifted multiplicand times the current digit
    assign partial   = mcand * {{(XLEN-STEP){1'b0}}, mplier[STEP-1:0]};
    assign product_o = acc;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy     <= 1'b0;
            done_o   <= 1'b0;
            step_cnt <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == CW'(NSTEPS - 1)) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            mcand  <= a_i;
            mplier <= b_i;
            acc    <= '0;
        end else if (busy) begin
            acc    <= acc + partial;
            mcand  <= mcand << STEP;
            mplier <= mplier >> STEP;
        end
    end

    a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_i |-> !busy);

endmodule

//--- verilog/core_pkg.sv
//////////////////////////////////////////////////
// Core types
// Instruction views, decoded micro-op, fetch packet
// and retirement record
//////////////////////////////////////////////////
`include "core_params.svh"

package core_pkg;

    // R-type view of an instruction word
    typedef struct packed {
        logic [6:0]              funct7;
        logic [`CORE_REG_AW-1:0] rs2;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } instr_r_s;

    // I-type view of an instruction word
    typedef struct packed {
        logic [11:0]             imm;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } instr_i_s;

    typedef union packed {
        instr_r_s r;
        instr_i_s i;
    } instr_word_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_MUL, ALU_ILLEGAL
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] instr;
    } fetch_slot_s;

    // Slot 0 is the older instruction
    typedef struct packed {
        fetch_slot_s [1:0] slot;
    } fetch_pkt_s;

    // Queue entry
    typedef struct packed {
        logic [`CORE_XLEN-1:0]   pc;
        alu_op_e                 op;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [`CORE_REG_AW-1:0] rs2;
        logic                    use_imm;
        logic [`CORE_XLEN-1:0]   imm;
    } dec_op_s;

    typedef struct packed {
        logic                    valid;
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   wdata;
        logic                    illegal;
    } retire_s;

endpackage

//--- include/core_params.svh
//////////////////////////////////////////////////
// Core parameters
// Widths, register count, queue depth and the
// multiplier digit size of the dual-slot core
//////////////////////////////////////////////////
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data and instruction width
`define CORE_XLEN 32

// Architectural registers, x0 reads as zero
`define CORE_NUM_REGS 32
`define CORE_REG_AW 5

// Instruction queue entries, power of two
`define CORE_QUEUE_DEPTH 8

// Multiplier bits consumed per cycle
`define CORE_MUL_STEP 8

`endif
